// File: src.f
+incdir+common
common/debug_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
verilog/debug_cmd_decode.sv
verilog/debug_exec.sv
verilog/debug_report.sv
verilog/debug_unit.sv
sim/debug_unit_checker.sv
sim/debug_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module debug_unit_tb -o debug_unit_sim

status=0
out=$(./obj_dir/debug_unit_sim 2>&1) || status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
printf '%s\n' "$out" | grep -q "^TEST RESULT: PASS$"

// File: sim/debug_unit_tb.sv
`timescale 1ns/1ps
`include "debug_settings.svh"

module debug_unit_tb;

    import debug_pkg::*;

    localparam int CLKS      = `DBG_CLKS_PER_BIT;
    localparam int N_WORDS   = 8;
    localparam int BYTES_OUT = 9 + 4 * N_WORDS;  // ping, program, pause, resume, next
    localparam int BYTES_IN  = 1 + 3 * 13;       // ok reply and three frames
    localparam int LIMIT     = (BYTES_OUT + BYTES_IN + 20) * 10 * CLKS + 1000;

    logic                       clk;
    logic                       rst_n;
    logic                       uart_rx;
    logic                       uart_tx;
    logic [`DBG_ISA_WIDTH-1:0]  pc_next;
    cpu_probe_t                 probe;
    mem_write_t                 mem_write;
    logic                       program_active;
    logic                       program_done;
    logic                       debug_pause;

    logic [31:0]                lfsr;
    logic [31:0]                bp_model;      // breakpoint the DUT should hold
    int                         errors = 0;
    int                         checks = 0;
    int                         framing_errs = 0;
    int                         cycles = 0;
    int                         low_run = 0;
    int                         last_low = 0;  // length of the latest low stretch
    int                         pause_rises = 0;
    logic [7:0]                 tx_bytes[$];
    logic [`DBG_ADDR_WIDTH-1:0] we_addr[$];
    logic [31:0]                we_data[$];
    logic                       we_active[$];

    debug_unit debug_unit_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .uart_rx        (uart_rx),
        .uart_tx        (uart_tx),
        .pc_next        (pc_next),
        .probe          (probe),
        .mem_write      (mem_write),
        .program_active (program_active),
        .program_done   (program_done),
        .debug_pause    (debug_pause)
    );

    bind debug_unit debug_unit_checker checker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_write    (mem_write),
        .program_done (program_done),
        .debug_pause  (debug_pause),
        .uart_tx      (uart_tx)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // program writes and the length of each run phase
    always @(negedge clk) begin
        if (mem_write.we === 1'b1) begin
            we_addr.push_back(mem_write.addr);
            we_data.push_back(mem_write.data);
            we_active.push_back(program_active);
        end
        if (debug_pause === 1'b0) begin
            low_run = low_run + 1;
        end else if (low_run != 0) begin
            last_low    = low_run;
            pause_rises = pause_rises + 1;
            low_run     = 0;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        errors++;
        $display("[ERROR] %0t ns %s expected %0h got %0h", $time, name, exp, got);
    endtask

    task automatic send_byte(input logic [7:0] b);
        uart_rx = 1'b0;                     // start bit
        repeat (CLKS) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            uart_rx = b[i];
            repeat (CLKS) @(negedge clk);
        end
        uart_rx = 1'b1;                     // stop bit
        repeat (CLKS) @(negedge clk);
    endtask

    task automatic send_word(input logic [31:0] w);
        for (int k = 0; k < 4; k++) send_byte(w[8*k +: 8]);
    endtask

    task automatic monitor_tx();
        logic [7:0] b;
        forever begin
            @(negedge clk);
            if (uart_tx === 1'b0) begin
                repeat (CLKS / 2) @(negedge clk);  // middle of start bit
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS) @(negedge clk);
                    b[i] = uart_tx;
                end
                repeat (CLKS) @(negedge clk);
                if (uart_tx !== 1'b1) begin
                    framing_errs++;
                    $display("stop bit missing on uart_tx at %0t ns", $time);
                end
                tx_bytes.push_back(b);
            end
        end
    endtask

    // cpu model keeps pc off the breakpoint
    task automatic set_cpu_state();
        logic [31:0] v;
        draw_bits(32, v);
        while (v == bp_model) draw_bits(32, v);
        pc_next = v;
        draw_bits(32, v);
        probe.pc = v;
        draw_bits(32, v);
        probe.instruction = v;
        draw_bits(32, v);
        probe.wb_result = v;
    endtask

    task automatic wait_for_bytes(input int n);
        while (tx_bytes.size() < n) @(negedge clk);
    endtask

    task automatic check_frame(input int base);
        logic [95:0] words;
        logic [7:0]  exp_b;
        words = {probe.wb_result, probe.instruction, probe.pc};
        wait_for_bytes(base + 13);
        checks++;
        if (tx_bytes[base] !== 8'h01) report_mismatch("frame opcode", 32'h01, 32'(tx_bytes[base]));
        for (int k = 0; k < 12; k++) begin
            exp_b = words[8*k +: 8];        // lsb first from pc up to wb_result
            if (tx_bytes[base+1+k] !== exp_b)
                report_mismatch("frame byte", 32'(exp_b), 32'(tx_bytes[base+1+k]));
        end
    endtask

    initial begin
        monitor_tx();
    end

    initial begin
        logic [31:0] words[N_WORDS];
        logic [31:0] bp;
        int          base;
        int          rises;
        lfsr     = 32'ha3ea;
        bp_model = '0;
        rst_n    = 1'b0;
        uart_rx  = 1'b1;
        pc_next  = '0;
        probe    = '0;
        set_cpu_state();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        checks++;
        if (debug_pause !== 1'b1) report_mismatch("debug_pause", 32'h1, 32'(debug_pause));
        if (uart_tx !== 1'b1) report_mismatch("uart_tx", 32'h1, 32'(uart_tx));
        if (program_active !== 1'b0) report_mismatch("program_active", 32'h0, 32'(program_active));

        base = tx_bytes.size();
        send_byte(8'h03);
        wait_for_bytes(base + 1);
        repeat (30 * CLKS) @(negedge clk);   // room for a stray second byte
        checks++;
        if (tx_bytes.size() != base + 1) begin
            errors++;
            $display("ping answered with %0d bytes instead of one", tx_bytes.size() - base);
        end
        if (tx_bytes[base] !== 8'h02) report_mismatch("ping reply", 32'h02, 32'(tx_bytes[base]));
        if (debug_pause !== 1'b1) report_mismatch("debug_pause", 32'h1, 32'(debug_pause));
        if (we_addr.size() != 0) begin
            errors++;
            $display("mem_write.we pulsed before any program load");
        end

        send_byte(8'h07);
        for (int w = 0; w < N_WORDS; w++) begin
            draw_bits(32, words[w]);
            send_word(words[w]);
        end
        while (program_done !== 1'b1) @(negedge clk);  // line idle ends the load
        checks++;
        if (debug_pause !== 1'b0) report_mismatch("debug_pause", 32'h0, 32'(debug_pause));
        if (program_active !== 1'b0) report_mismatch("program_active", 32'h0, 32'(program_active));
        if (we_addr.size() != N_WORDS) begin
            errors++;
            $display("%0d program writes seen instead of %0d", we_addr.size(), N_WORDS);
        end else begin
            for (int w = 0; w < N_WORDS; w++) begin
                if (we_addr[w] !== `DBG_ADDR_WIDTH'(w))
                    report_mismatch("mem_write.addr", 32'(w), 32'(we_addr[w]));
                if (we_data[w] !== words[w])
                    report_mismatch("mem_write.data", words[w], we_data[w]);
                if (we_active[w] !== 1'b1) begin
                    errors++;
                    $display("program_active was low during write %0d", w);
                end
            end
        end

        set_cpu_state();
        base = tx_bytes.size();
        send_byte(8'h04);
        check_frame(base);
        if (debug_pause !== 1'b1) report_mismatch("debug_pause", 32'h1, 32'(debug_pause));

        draw_bits(32, bp);
        bp_model = bp;
        set_cpu_state();
        base = tx_bytes.size();
        send_byte(8'h05);
        checks++;
        if (debug_pause !== 1'b1) report_mismatch("debug_pause", 32'h1, 32'(debug_pause));
        send_word(bp);
        while (debug_pause !== 1'b0) @(negedge clk);
        repeat (4 * CLKS) @(negedge clk);    // cpu runs off the breakpoint
        if (debug_pause !== 1'b0) report_mismatch("debug_pause", 32'h0, 32'(debug_pause));
        pc_next = bp;
        @(negedge clk);
        if (debug_pause !== 1'b1) report_mismatch("debug_pause", 32'h1, 32'(debug_pause));
        check_frame(base);

        set_cpu_state();
        base  = tx_bytes.size();
        rises = pause_rises;
        send_byte(8'h06);
        while (pause_rises == rises) @(negedge clk);
        checks++;
        if (last_low != 1) report_mismatch("debug_pause low cycles", 32'h1, last_low);
        check_frame(base);
        if (debug_pause !== 1'b1) report_mismatch("debug_pause", 32'h1, 32'(debug_pause));

        repeat (2 * CLKS) @(negedge clk);
        $display("checks: %0d, errors: %0d, stop bit errors: %0d, assertion failures: %0d",
                 checks, errors, framing_errs, debug_unit_i.checker_i.assert_fails);
        if (errors + framing_errs + debug_unit_i.checker_i.assert_fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sim/debug_unit_checker.sv
`timescale 1ns/1ps

module debug_unit_checker (
    input logic                  clk,
    input logic                  rst_n,
    input debug_pkg::mem_write_t mem_write,
    input logic                  program_done,
    input logic                  debug_pause,
    input logic                  uart_tx
);

    int assert_fails = 0;  // failed assertion count

    we_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) mem_write.we |=> !mem_write.we
    ) else begin
        $error("mem_write.we stayed high for a second cycle");
        assert_fails++;
    end

    done_releases_cpu: assert property (
        @(posedge clk) disable iff (!rst_n) program_done |-> !debug_pause
    ) else begin
        $error("debug_pause still high with program_done");
        assert_fails++;
    end

    line_idle_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> uart_tx
    ) else begin
        $error("uart_tx low when reset was released");
        assert_fails++;
    end

endmodule

// File: verilog/debug_unit.sv
`timescale 1ns/1ps
`include "debug_settings.svh"

module debug_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      uart_rx,
    output logic                      uart_tx,
    input  logic [`DBG_ISA_WIDTH-1:0] pc_next,
    input  debug_pkg::cpu_probe_t     probe,
    output debug_pkg::mem_write_t     mem_write,
    output logic                      program_active,
    output logic                      program_done,
    output logic                      debug_pause
);

    import debug_pkg::*;

    logic       rx_valid;
    logic [7:0] rx_byte;
    logic       rx_idle;
    dbg_cmd_t   cmd;           // decode to exec and report
    logic       frame_start;

    uart_rx uart_rx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .uart_rx  (uart_rx),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .rx_idle  (rx_idle)
    );

    debug_cmd_decode cmd_decode_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_valid (rx_valid),
        .rx_byte  (rx_byte),
        .rx_idle  (rx_idle),
        .cmd      (cmd)
    );

    debug_exec exec_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd            (cmd),
        .pc_next        (pc_next),
        .debug_pause    (debug_pause),
        .mem_write      (mem_write),
        .program_active (program_active),
        .program_done   (program_done),
        .frame_start    (frame_start)
    );

    debug_report report_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .ping        (cmd.ping),
        .probe       (probe),
        .uart_tx     (uart_tx)
    );

endmodule

// File: verilog/debug_report.sv
`timescale 1ns/1ps

module debug_report (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  frame_start,
    input  logic                  ping,
    input  debug_pkg::cpu_probe_t probe,
    output logic                  uart_tx
);

    import debug_pkg::*;

    localparam int PROBE_W     = $bits(cpu_probe_t);
    localparam int FRAME_BYTES = 1 + PROBE_W / 8;  // opcode plus probe words

    typedef enum logic [1:0] {rp_idle, rp_signal, rp_ping} rp_state_t;

    rp_state_t          state;
    logic [PROBE_W-1:0] frame_sr;
    logic [3:0]         byte_cnt;  // bytes handed to the transmitter
    logic               tx_start;
    logic [7:0]         tx_byte;
    logic               tx_busy;
    logic               tx_done;
    logic               take_frame;
    logic               take_ping;
    logic               next_byte;

    assign take_frame = (state == rp_idle) && !tx_busy && frame_start;
    assign take_ping  = (state == rp_idle) && !tx_busy && !frame_start && ping;
    assign next_byte  = (state == rp_signal) && tx_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= rp_idle;
            byte_cnt <= '0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            case (state)
                rp_idle: begin
                    if (take_frame) begin
                        state    <= rp_signal;
                        byte_cnt <= 4'd1;
                        tx_start <= 1'b1;
                    end else if (take_ping) begin
                        state    <= rp_ping;
                        tx_start <= 1'b1;
                    end
                end
                rp_signal: if (next_byte) begin
                    if (byte_cnt == 4'(FRAME_BYTES)) begin
                        state <= rp_idle;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                        tx_start <= 1'b1;
                    end
                end
                rp_ping: if (tx_done) state <= rp_idle;
                default: state <= rp_idle;
            endcase
        end
    end

    // probe captured once, then shifted out lowest byte first
    always_ff @(posedge clk) begin
        if (take_frame) begin
            frame_sr <= {probe.wb_result, probe.instruction, probe.pc};
            tx_byte  <= op_signal;
        end else if (take_ping) begin
            tx_byte <= op_ok;
        end else if (next_byte) begin
            tx_byte  <= frame_sr[7:0];
            frame_sr <= frame_sr >> 8;
        end
    end

    uart_tx uart_tx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .uart_tx  (uart_tx),
        .tx_busy  (tx_busy),
        .tx_done  (tx_done)
    );

endmodule

// File: verilog/debug_exec.sv
`timescale 1ns/1ps
`include "debug_settings.svh"

module debug_exec (
    input  logic                      clk,
    input  logic                      rst_n,
    input  debug_pkg::dbg_cmd_t       cmd,
    input  logic [`DBG_ISA_WIDTH-1:0] pc_next,
    output logic                      debug_pause,
    output debug_pkg::mem_write_t     mem_write,
    output logic                      program_active,
    output logic                      program_done,
    output logic                      frame_start
);

    logic [`DBG_ISA_WIDTH-1:0]  breakpoint;
    logic                       step_pending;
    logic [`DBG_ADDR_WIDTH-1:0] prog_addr;     // last written word address
    logic                       stop_event;

    // cpu reached the breakpoint or finished a single step
    assign stop_event = !debug_pause && ((pc_next == breakpoint) || step_pending);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            debug_pause    <= 1'b1;
            breakpoint     <= '0;
            step_pending   <= 1'b0;
            prog_addr      <= '1;
            mem_write      <= '0;
            program_active <= 1'b0;
            program_done   <= 1'b0;
            frame_start    <= 1'b0;
        end else begin
            mem_write.we <= 1'b0;
            program_done <= 1'b0;
            frame_start  <= 1'b0;

            if (stop_event) begin
                debug_pause  <= 1'b1;
                frame_start  <= 1'b1;
                step_pending <= 1'b0;
            end

            if (cmd.pause) begin
                debug_pause <= 1'b1;
                frame_start <= 1'b1;
            end
            if (cmd.next) begin                     // run for one cycle
                debug_pause  <= 1'b0;
                step_pending <= 1'b1;
            end
            if (cmd.resume) begin
                breakpoint  <= cmd.word;
                debug_pause <= 1'b0;
            end

            if (cmd.program_start) program_active <= 1'b1;
            if (cmd.program_word) begin
                mem_write.we   <= 1'b1;
                mem_write.addr <= prog_addr + 1'b1;
                mem_write.data <= cmd.word;
                prog_addr      <= prog_addr + 1'b1;
            end
            if (cmd.program_end) begin
                program_active <= 1'b0;
                program_done   <= 1'b1;
                debug_pause    <= 1'b0;
                breakpoint     <= '0;
                prog_addr      <= '1;
            end
        end
    end

endmodule

// File: verilog/debug_cmd_decode.sv
`timescale 1ns/1ps
`include "debug_settings.svh"

module debug_cmd_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rx_valid,
    input  logic [7:0]          rx_byte,
    input  logic                rx_idle,
    output debug_pkg::dbg_cmd_t cmd
);

    import debug_pkg::*;

    localparam int WORD_BYTES = `DBG_ISA_WIDTH / 8;
    localparam int IDX_W      = $clog2(WORD_BYTES);
    localparam logic [IDX_W-1:0] LAST_BYTE = IDX_W'(WORD_BYTES - 1);

    typedef enum logic [1:0] {st_opcode, st_breakpoint, st_program} dec_state_t;

    dec_state_t                state;
    dbg_opcode_t               opcode;
    logic [IDX_W-1:0]          byte_idx;
    logic [`DBG_ISA_WIDTH-1:0] word_sr;
    logic [`DBG_ISA_WIDTH-1:0] word_next;

    assign opcode    = dbg_opcode_t'(rx_byte);
    assign word_next = {rx_byte, word_sr[`DBG_ISA_WIDTH-1:8]}; // little endian

    always_ff @(posedge clk) begin
        if (rx_valid) word_sr <= word_next;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_opcode;
            byte_idx <= '0;
            cmd      <= '0;
        end else begin
            cmd.ping          <= 1'b0;
            cmd.pause         <= 1'b0;
            cmd.resume        <= 1'b0;
            cmd.next          <= 1'b0;
            cmd.program_start <= 1'b0;
            cmd.program_word  <= 1'b0;
            cmd.program_end   <= 1'b0;
            case (state)
                st_opcode: if (rx_valid) begin
                    byte_idx <= '0;
                    case (opcode)
                        op_ping:   cmd.ping  <= 1'b1;
                        op_pause:  cmd.pause <= 1'b1;
                        op_next:   cmd.next  <= 1'b1;
                        op_resume: state     <= st_breakpoint;
                        op_program: begin
                            cmd.program_start <= 1'b1;
                            state             <= st_program;
                        end
                        default: ;                  // unknown byte dropped
                    endcase
                end
                st_breakpoint: if (rx_valid) begin
                    byte_idx <= byte_idx + 1'b1;
                    if (byte_idx == LAST_BYTE) begin
                        cmd.resume <= 1'b1;
                        cmd.word   <= word_next;
                        state      <= st_opcode;
                    end
                end
                st_program: begin
                    if (rx_idle) begin              // quiet line ends the load
                        cmd.program_end <= 1'b1;
                        byte_idx        <= '0;
                        state           <= st_opcode;
                    end else if (rx_valid) begin
                        byte_idx <= byte_idx + 1'b1;
                        if (byte_idx == LAST_BYTE) begin
                            cmd.program_word <= 1'b1;
                            cmd.word         <= word_next;
                        end
                    end
                end
                default: state <= st_opcode;
            endcase
        end
    end

endmodule

// File: uart/uart_tx.sv
`timescale 1ns/1ps
`include "debug_settings.svh"

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_byte,
    output logic       uart_tx,
    output logic       tx_busy,
    output logic       tx_done
);

    localparam int CLKS  = `DBG_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(CLKS - 1);

    logic [CNT_W-1:0] cnt;
    logic [3:0]       bit_idx;    // 0 start, 1..8 data, 9 stop
    logic [8:0]       shift;      // data bits and stop bit still to go
    logic             load;
    logic             advance;

    assign load    = tx_start && !tx_busy;
    assign advance = tx_busy && (cnt == FULL) && (bit_idx != 4'd9);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            uart_tx <= 1'b1;
            tx_busy <= 1'b0;
            tx_done <= 1'b0;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            tx_done <= 1'b0;
            if (load) begin
                uart_tx <= 1'b0;          // start bit
                tx_busy <= 1'b1;
                cnt     <= '0;
                bit_idx <= '0;
            end else if (tx_busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == FULL) begin
                    cnt <= '0;
                    if (bit_idx == 4'd9) begin
                        tx_busy <= 1'b0;
                        tx_done <= 1'b1;  // end of stop bit
                        uart_tx <= 1'b1;
                    end else begin
                        uart_tx <= shift[0];
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shift <= {1'b1, tx_byte};
        end else if (advance) begin
            shift <= {1'b1, shift[8:1]};
        end
    end

endmodule

// File: uart/uart_rx.sv
`timescale 1ns/1ps
`include "debug_settings.svh"

module uart_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_rx,
    output logic       rx_valid,
    output logic [7:0] rx_byte,
    output logic       rx_idle
);

    localparam int CLKS  = `DBG_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CLKS);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(CLKS - 1);
    localparam logic [CNT_W-1:0] HALF = CNT_W'(CLKS / 2 - 1);

    typedef enum logic [2:0] {st_idle, st_start, st_data, st_stop, st_wait} rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_s;
    logic [CNT_W-1:0] cnt;
    logic [3:0]       bit_idx;    // data bit index, then bit periods while waiting
    logic [7:0]       rx_shift;
    logic             sample_bit;
    logic             stop_hit;

    assign sample_bit = (state == st_data) && (cnt == FULL);
    assign stop_hit   = (state == st_stop) && (cnt == FULL);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_s    <= rx_meta;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
            rx_idle  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            rx_idle  <= 1'b0;
            cnt      <= cnt + 1'b1;
            case (state)
                st_idle: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (!rx_s) state <= st_start;
                end
                st_start: if (cnt == HALF) begin
                    cnt   <= '0;
                    state <= rx_s ? st_idle : st_data; // high at midpoint is a glitch
                end
                st_data: if (sample_bit) begin
                    cnt     <= '0;
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 4'd7) state <= st_stop;
                end
                st_stop: if (stop_hit) begin
                    cnt      <= '0;
                    bit_idx  <= '0;
                    rx_valid <= 1'b1;
                    state    <= st_wait;
                end
                st_wait: begin
                    if (!rx_s) begin                  // next start bit
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= st_start;
                    end else if (cnt == FULL) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 4'd9) begin    // one byte time of high line
                            rx_idle <= 1'b1;
                            state   <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sample_bit) rx_shift <= {rx_s, rx_shift[7:1]}; // lsb first
        if (stop_hit) rx_byte <= rx_shift;
    end

endmodule

// File: common/debug_pkg.sv
`include "debug_settings.svh"

package debug_pkg;

    // opcodes on the serial link
    typedef enum logic [7:0] {
        op_signal  = 8'h01, // cpu state frame to the host
        op_ok      = 8'h02, // ping reply to the host
        op_ping    = 8'h03,
        op_pause   = 8'h04,
        op_resume  = 8'h05, // followed by a 4-byte breakpoint
        op_next    = 8'h06,
        op_program = 8'h07  // followed by words until the line idles
    } dbg_opcode_t;

    typedef struct packed {
        logic [`DBG_ISA_WIDTH-1:0] pc;
        logic [`DBG_ISA_WIDTH-1:0] instruction;
        logic [`DBG_ISA_WIDTH-1:0] wb_result;
    } cpu_probe_t;

    typedef struct packed {
        logic                       we;
        logic [`DBG_ADDR_WIDTH-1:0] addr;
        logic [`DBG_ISA_WIDTH-1:0]  data;
    } mem_write_t;

    typedef struct packed {
        logic                      ping;
        logic                      pause;
        logic                      resume;
        logic                      next;
        logic                      program_start;
        logic                      program_word;
        logic                      program_end;
        logic [`DBG_ISA_WIDTH-1:0] word;          // breakpoint or program word
    } dbg_cmd_t;

endpackage

// File: common/debug_settings.svh
`ifndef DEBUG_SETTINGS_SVH
`define DEBUG_SETTINGS_SVH

// width of a CPU word, a breakpoint and a program word
`define DBG_ISA_WIDTH 32

// clock cycles per UART bit
// 868 would suit 115200 baud from a 100 MHz clock
`define DBG_CLKS_PER_BIT 16

// program memory address width, in words
`define DBG_ADDR_WIDTH 14

`endif
